/* build.f */
+incdir+common
common/lsu_pkg.sv
lsu/lsu_agen.sv
lsu/lsu_data_ram.sv
lsu/lsu_load_align.sv
verilog/lsu_top.sv
testbench/lsu_assertions.sv
testbench/lsu_tb.sv

/* Bender.yml */
package:
  name: lsu

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/lsu_pkg.sv
      - lsu/lsu_agen.sv
      - lsu/lsu_data_ram.sv
      - lsu/lsu_load_align.sv
      - verilog/lsu_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/lsu_assertions.sv
      - testbench/lsu_tb.sv

/* testbench/lsu_tb.sv */
`timescale 1ns/1ps

`include "lsu_consts.svh"

module lsu_tb
  import lsu_pkg::*;
();

  localparam int ram_bytes = `LSU_RAM_WORDS * 8;
  localparam logic [63:0] ram_base = `LSU_RAM_BASE;

  typedef struct packed {
    logic        fault;
    logic [63:0] rdata;
    logic [31:0] cycle;
  } exp_t;

  logic     clk;
  logic     reset;
  lsu_req_t req;
  lsu_rsp_t rsp;

  // rising edges seen so far, bumped just before each edge
  int          edge_cnt = 0;
  logic [63:0] lcg_state = 64'd66;
  logic [7:0]  model_mem [ram_bytes];
  exp_t        exp_q [$];

  // below, at and far outside the ram window
  logic [63:0] outside_addr [6] = '{
    ram_base - 64'd8,
    ram_base - 64'd1,
    ram_base + 64'(ram_bytes),
    ram_base + 64'(ram_bytes) + 64'd8,
    64'h0,
    64'hffff_ffff_ffff_fff8
  };

  lsu_top lsu_top_i (
    .clk   (clk),
    .reset (reset),
    .req   (req),
    .rsp   (rsp)
  );

  bind lsu_top lsu_assertions lsu_assertions_i (
    .clk     (clk),
    .reset   (reset),
    .req     (req),
    .ram_cmd (ram_cmd),
    .ram_rsp (ram_rsp),
    .rsp     (rsp)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #50;
      edge_cnt = edge_cnt + 1;
      clk = 1'b1;
      #50;
      clk = 1'b0;
    end
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
    return lcg_state[63:32];
  endfunction

  function automatic logic [63:0] rand64();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = next_rand();
    lo = next_rand();
    return {hi, lo};
  endfunction

  function automatic logic rand_bit();
    logic [31:0] v;
    v = next_rand();
    return v[31];
  endfunction

  // one of the first count sizes
  function automatic lsu_size_e rand_size(input int count);
    logic [31:0] v;
    v = next_rand() % count;
    return lsu_size_e'(v[1:0]);
  endfunction

  // random in-window address aligned to the access size
  function automatic logic [63:0] aligned_addr(input lsu_size_e size);
    int n;
    int word;
    int off;
    n = 1 << size;
    word = int'(next_rand() % `LSU_RAM_WORDS);
    off = int'(next_rand() % 8) & ~(n - 1);
    return ram_base + 64'(word * 8 + off);
  endfunction

  // little-endian bytes from the model, then sign or zero fill
  function automatic logic [63:0] expected_load(input logic [63:0] addr,
                                                input lsu_size_e size,
                                                input logic is_unsigned);
    logic [63:0] value;
    int          n;
    int          base;
    value = '0;
    n = 1 << size;
    base = int'(addr - ram_base);
    for (int b = 0; b < n; b++) begin
      value[8*b +: 8] = model_mem[base + b];
    end
    if (!is_unsigned && value[8*n-1]) begin
      for (int b = n; b < 8; b++) begin
        value[8*b +: 8] = 8'hff;
      end
    end
    return value;
  endfunction

  task automatic stop_on_failure(input string reason);
    $display("%s at time %0t", reason, $time);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("ERR time=%0t %s actual=%h expected=%h", $time, name, actual, expected);
      $display("STATUS: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // model update and expected response are fixed at issue time
  task automatic send_req(input logic write, input lsu_size_e size,
                          input logic is_unsigned, input logic [63:0] addr,
                          input logic [63:0] wdata);
    lsu_req_t r;
    exp_t     e;
    logic     in_window;
    logic     misaligned;
    int       n;
    int       base;
    n = 1 << size;
    in_window = (addr >= ram_base) && (addr < ram_base + 64'(ram_bytes));
    misaligned = ((addr & 64'(n - 1)) != 64'h0);
    e.fault = !in_window || misaligned;
    e.rdata = '0;
    if (!e.fault) begin
      base = int'(addr - ram_base);
      if (write) begin
        for (int b = 0; b < n; b++) begin
          model_mem[base + b] = wdata[8*b +: 8];
        end
      end else begin
        e.rdata = expected_load(addr, size, is_unsigned);
      end
    end
    r.valid = 1'b1;
    r.write = write;
    r.size = size;
    r.is_unsigned = is_unsigned;
    r.addr = addr;
    r.wdata = wdata;
    @(posedge clk);
    req <= r;
    e.cycle = edge_cnt;
    exp_q.push_back(e);
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    req <= '0;
  endtask

  task automatic drain();
    int wait_cnt;
    idle_cycle();
    wait_cnt = 0;
    while (exp_q.size() != 0) begin
      if (wait_cnt > 4 * `LSU_LATENCY) begin
        stop_on_failure("timeout waiting for outstanding responses");
      end else begin
        @(posedge clk);
        wait_cnt++;
      end
    end
  endtask

  // responses are registered, so the falling edge sees them settled
  always @(negedge clk) begin
    exp_t e;
    if (lsu_top_i.lsu_assertions_i.error_count != 0) begin
      stop_on_failure("a bound assertion failed");
    end else if (!reset) begin
      if (rsp.valid === 1'b1) begin
        if (exp_q.size() == 0) begin
          stop_on_failure("response strobe with no request pending");
        end else begin
          e = exp_q.pop_front();
          check_value("rsp.fault", 64'(rsp.fault), 64'(e.fault));
          check_value("rsp.rdata", rsp.rdata, e.rdata);
          check_value("rsp.valid cycle", 64'(edge_cnt), 64'(e.cycle + `LSU_LATENCY));
        end
      end else if (rsp.valid !== 1'b0) begin
        stop_on_failure("rsp.valid is unknown after reset");
      end
    end
  end

  initial begin
    lsu_size_e   size;
    logic [63:0] addr;
    int          off;
    lsu_req_t    noise;
    reset = 1'b1;
    req = '0;

    // random strobes during reset must never get through
    repeat (14) begin
      size = rand_size(4);
      noise.valid = 1'b1;
      noise.write = rand_bit();
      noise.size = size;
      noise.is_unsigned = rand_bit();
      noise.addr = aligned_addr(size);
      noise.wdata = rand64();
      @(posedge clk);
      req <= noise;
    end
    @(posedge clk);
    req <= '0;
    @(posedge clk);
    reset <= 1'b0;

    // nothing may come out before the first request
    repeat (6) idle_cycle();

    // fill every word, then read it all back
    for (int w = 0; w < `LSU_RAM_WORDS; w++) begin
      send_req(1'b1, size_double, 1'b0, ram_base + 64'(w * 8), rand64());
    end
    for (int w = 0; w < `LSU_RAM_WORDS; w++) begin
      send_req(1'b0, size_double, 1'b0, ram_base + 64'(w * 8), '0);
    end
    drain();

    // narrow stores, neighbors checked by full-word loads
    for (int i = 0; i < 48; i++) begin
      size = rand_size(3);
      send_req(1'b1, size, 1'b0, aligned_addr(size), rand64());
    end
    for (int w = 0; w < `LSU_RAM_WORDS; w++) begin
      send_req(1'b0, size_double, 1'b0, ram_base + 64'(w * 8), '0);
    end
    drain();

    // every size, signed and unsigned
    for (int i = 0; i < 64; i++) begin
      size = rand_size(4);
      send_req(1'b0, size, rand_bit(), aligned_addr(size), '0);
    end
    drain();

    // misaligned accesses, each followed by a load of the whole word
    for (int i = 0; i < 24; i++) begin
      size = rand_size(3);
      if (size == size_byte) begin
        size = size_double;
      end
      off = int'(next_rand() % 8);
      if (off % (1 << size) == 0) begin
        off = off + 1;
      end
      addr = ram_base + 64'(int'(next_rand() % `LSU_RAM_WORDS) * 8 + off);
      send_req(rand_bit(), size, rand_bit(), addr, rand64());
      send_req(1'b0, size_double, 1'b0, addr & ~64'h7, '0);
    end
    for (int i = 0; i < 6; i++) begin
      send_req(1'b1, size_double, 1'b0, outside_addr[i], rand64());
      send_req(1'b0, size_double, 1'b0, outside_addr[i], '0);
      send_req(1'b0, size_byte, 1'b0, outside_addr[i], '0);
    end
    drain();

    // store then load of the same address on the next cycle
    for (int i = 0; i < 32; i++) begin
      size = rand_size(4);
      addr = aligned_addr(size);
      send_req(1'b1, size, 1'b0, addr, rand64());
      send_req(1'b0, size, rand_bit(), addr, '0);
      if (next_rand() % 4 == 0) begin
        idle_cycle();
      end
    end
    drain();

    // idle tail, any stray strobe is caught by the monitor
    repeat (5) idle_cycle();

    if (lsu_top_i.lsu_assertions_i.error_count != 0) begin
      stop_on_failure("bound assertions reported failures");
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

/* testbench/lsu_assertions.sv */
`timescale 1ns/1ps

`include "lsu_consts.svh"

module lsu_assertions
  import lsu_pkg::*;
(
  input logic         clk,
  input logic         reset,
  input lsu_req_t     req,
  input lsu_ram_cmd_t ram_cmd,
  input lsu_ram_rsp_t ram_rsp,
  input lsu_rsp_t     rsp
);

  // polled by the testbench monitor every cycle
  int unsigned error_count = 0;

  // each request comes back after the fixed latency
  req_to_rsp: assert property (@(posedge clk) disable iff (reset)
    req.valid |-> ##`LSU_LATENCY rsp.valid)
    else begin
      error_count++;
      $error("no response %0d cycles after a request", `LSU_LATENCY);
    end

  // and no response without one
  rsp_from_req: assert property (@(posedge clk) disable iff (reset)
    rsp.valid |-> $past(req.valid, `LSU_LATENCY))
    else begin
      error_count++;
      $error("response without a matching request");
    end

  // pipeline stays empty while in reset
  reset_quiet: assert property (@(posedge clk)
    reset |=> !(ram_cmd.valid || ram_rsp.valid || rsp.valid))
    else begin
      error_count++;
      $error("valid bit high during reset");
    end

  fault_no_write: assert property (@(posedge clk) disable iff (reset)
    (ram_cmd.valid && ram_cmd.fault) |-> (ram_cmd.byte_mask == 8'h00))
    else begin
      error_count++;
      $error("faulted command carries a byte mask");
    end

  fault_no_data: assert property (@(posedge clk) disable iff (reset)
    (rsp.valid && rsp.fault) |-> (rsp.rdata == '0))
    else begin
      error_count++;
      $error("faulted response carries data");
    end

endmodule

/* verilog/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top
  import lsu_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  // one request strobe per cycle at most
  input  lsu_req_t req,
  // response three cycles after its request
  output lsu_rsp_t rsp
);

  // stage 1 out
  lsu_ram_cmd_t ram_cmd;
  // stage 2 out
  lsu_ram_rsp_t ram_rsp;

  // address check, byte mask, store lanes
  lsu_agen agen_i (
    .clk     (clk),
    .reset   (reset),
    .req     (req),
    .ram_cmd (ram_cmd)
  );

  // masked write, registered read
  lsu_data_ram data_ram_i (
    .clk     (clk),
    .reset   (reset),
    .ram_cmd (ram_cmd),
    .ram_rsp (ram_rsp)
  );

  // shift down and extend load data
  lsu_load_align load_align_i (
    .clk     (clk),
    .reset   (reset),
    .ram_rsp (ram_rsp),
    .rsp     (rsp)
  );

endmodule

/* lsu/lsu_load_align.sv */
`timescale 1ns/1ps

`include "lsu_consts.svh"

module lsu_load_align
  import lsu_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  lsu_ram_rsp_t ram_rsp,
  output lsu_rsp_t     rsp
);

  logic [`LSU_XLEN-1:0] shifted;
  logic                 sign_bit;
  logic [`LSU_XLEN-1:0] extended;
  logic                 zero_data;

  // addressed byte down to bit 0
  assign shifted = ram_rsp.rdata >> {ram_rsp.offset, 3'b000};

  // top kept bit, or zero for unsigned loads
  always_comb begin
    case (ram_rsp.size)
      size_byte:   sign_bit = shifted[7];
      size_half:   sign_bit = shifted[15];
      size_word:   sign_bit = shifted[31];
      size_double: sign_bit = shifted[63];
      default:     sign_bit = 1'b0;
    endcase
    sign_bit = sign_bit & ~ram_rsp.is_unsigned;
  end

  always_comb begin
    case (ram_rsp.size)
      size_byte: begin
        extended = {{56{sign_bit}}, shifted[7:0]};
      end
      size_half: begin
        extended = {{48{sign_bit}}, shifted[15:0]};
      end
      size_word: begin
        extended = {{32{sign_bit}}, shifted[31:0]};
      end
      default: begin
        extended = shifted;
      end
    endcase
  end

  // stores and faults return no data
  assign zero_data = ram_rsp.write | ram_rsp.fault;

  always_ff @(posedge clk) begin
    rsp.fault <= ram_rsp.fault;
    if (zero_data) begin
      rsp.rdata <= '0;
    end else begin
      rsp.rdata <= extended;
    end
    if (reset) begin
      rsp.valid <= 1'b0;
    end else begin
      rsp.valid <= ram_rsp.valid;
    end
  end

endmodule

/* lsu/lsu_data_ram.sv */
`timescale 1ns/1ps

`include "lsu_consts.svh"

module lsu_data_ram
  import lsu_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  lsu_ram_cmd_t ram_cmd,
  output lsu_ram_rsp_t ram_rsp
);

  // one double-word per entry
  logic [`LSU_XLEN-1:0] mem [`LSU_RAM_WORDS];

  // byte-lane write
  always_ff @(posedge clk) begin
    if (ram_cmd.valid) begin
      for (int lane = 0; lane < 8; lane++) begin
        if (ram_cmd.byte_mask[lane]) begin
          mem[ram_cmd.index][8*lane +: 8] <= ram_cmd.wdata[8*lane +: 8];
        end
      end
    end
  end

  // registered read sees the contents before this edge's write
  always_ff @(posedge clk) begin
    ram_rsp.rdata       <= mem[ram_cmd.index];
    ram_rsp.write       <= ram_cmd.write;
    ram_rsp.fault       <= ram_cmd.fault;
    ram_rsp.size        <= ram_cmd.size;
    ram_rsp.is_unsigned <= ram_cmd.is_unsigned;
    ram_rsp.offset      <= ram_cmd.offset;
    if (reset) begin
      ram_rsp.valid <= 1'b0;
    end else begin
      ram_rsp.valid <= ram_cmd.valid;
    end
  end

endmodule

/* lsu/lsu_agen.sv */
`timescale 1ns/1ps

`include "lsu_consts.svh"

module lsu_agen
  import lsu_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  lsu_req_t     req,
  output lsu_ram_cmd_t ram_cmd
);

  logic [2:0]           offset;
  logic [`LSU_XLEN-1:0] rel_addr;
  logic                 in_window;
  logic                 misaligned;
  logic                 fault;
  logic [7:0]           lane_mask;
  logic [7:0]           byte_mask;
  logic [`LSU_XLEN-1:0] wdata_lanes;

  assign offset = req.addr[2:0];

  // below the base wraps to a huge value, so one check covers both ends
  assign rel_addr  = req.addr - `LSU_RAM_BASE;
  assign in_window = (rel_addr[`LSU_XLEN-1:`LSU_RAM_IDX_W+3] == '0);

  // offset must be a multiple of the access size
  always_comb begin
    case (req.size)
      size_byte:   misaligned = 1'b0;
      size_half:   misaligned = offset[0];
      size_word:   misaligned = (offset[1:0] != 2'b00);
      size_double: misaligned = (offset != 3'b000);
      default:     misaligned = 1'b1;
    endcase
  end

  assign fault = req.valid & (~in_window | misaligned);

  // lanes touched by the access
  always_comb begin
    case (req.size)
      size_byte: begin
        lane_mask = 8'b0000_0001 << offset;
      end
      size_half: begin
        case (offset)
          3'd0:    lane_mask = 8'b0000_0011;
          3'd2:    lane_mask = 8'b0000_1100;
          3'd4:    lane_mask = 8'b0011_0000;
          3'd6:    lane_mask = 8'b1100_0000;
          default: lane_mask = 8'b0000_0000;
        endcase
      end
      size_word: begin
        case (offset)
          3'd0:    lane_mask = 8'b0000_1111;
          3'd4:    lane_mask = 8'b1111_0000;
          default: lane_mask = 8'b0000_0000;
        endcase
      end
      size_double: begin
        lane_mask = 8'b1111_1111;
      end
      default: begin
        lane_mask = 8'b0000_0000;
      end
    endcase
  end

  // only a good store may write
  assign byte_mask = lane_mask & {8{req.valid & req.write & ~fault}};

  // move store data up into its lanes
  assign wdata_lanes = req.wdata << {offset, 3'b000};

  always_ff @(posedge clk) begin
    ram_cmd.write       <= req.write;
    ram_cmd.fault       <= fault;
    ram_cmd.size        <= req.size;
    ram_cmd.is_unsigned <= req.is_unsigned;
    ram_cmd.offset      <= offset;
    ram_cmd.index       <= req.addr[`LSU_RAM_IDX_W+2:3];
    ram_cmd.byte_mask   <= byte_mask;
    ram_cmd.wdata       <= wdata_lanes;
    if (reset) begin
      ram_cmd.valid <= 1'b0;
    end else begin
      ram_cmd.valid <= req.valid;
    end
  end

endmodule

/* common/lsu_pkg.sv */
`include "lsu_consts.svh"

package lsu_pkg;

  // access size of a load or store
  typedef enum logic [1:0] {
    size_byte   = 2'd0,
    size_half   = 2'd1,
    size_word   = 2'd2,
    size_double = 2'd3
  } lsu_size_e;

  // request from the core, one strobe per access
  typedef struct packed {
    logic                 valid;
    logic                 write;
    lsu_size_e            size;
    logic                 is_unsigned;
    logic [`LSU_XLEN-1:0] addr;
    logic [`LSU_XLEN-1:0] wdata;
  } lsu_req_t;

  // stage 1 to stage 2
  typedef struct packed {
    logic                      valid;
    logic                      write;
    logic                      fault;
    lsu_size_e                 size;
    logic                      is_unsigned;
    logic [2:0]                offset;
    logic [`LSU_RAM_IDX_W-1:0] index;
    // zero on a fault or a load
    logic [7:0]                byte_mask;
    // store data already in its lanes
    logic [`LSU_XLEN-1:0]      wdata;
  } lsu_ram_cmd_t;

  // stage 2 to stage 3
  typedef struct packed {
    logic                 valid;
    logic                 write;
    logic                 fault;
    lsu_size_e            size;
    logic                 is_unsigned;
    logic [2:0]           offset;
    // raw double-word as read
    logic [`LSU_XLEN-1:0] rdata;
  } lsu_ram_rsp_t;

  // response to the core
  typedef struct packed {
    logic                 valid;
    logic                 fault;
    logic [`LSU_XLEN-1:0] rdata;
  } lsu_rsp_t;

endpackage

/* common/lsu_consts.svh */
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// data and address width
`define LSU_XLEN 64

// ram depth in double-words
`define LSU_RAM_WORDS 64

// word index width, log2 of the depth
`define LSU_RAM_IDX_W 6

// start of the ram window
`define LSU_RAM_BASE 64'h0000_0000_8000_0000

// cycles from a request edge to its response
`define LSU_LATENCY 3

`endif
